/* project.f */
logic/mul_pkg.sv
logic/mul_op_if.sv
logic/delay_line.sv
logic/operand_prep.sv
logic/karatsuba_mul32.sv
logic/product_fix.sv
logic/mul32_unit.sv
sim/tb_mul32_unit.sv

/* sim/tb_mul32_unit.sv */
// testbench for mul32_unit; expects 8 ce-enabled edges of latency and sync reset, needs no input files
`timescale 1ns/100ps

module tb_mul32_unit;

  localparam logic [31:0] seed = 32'hcdc78975;
  localparam int n_unsigned     = 1000;
  localparam int n_mixed        = 1500;
  localparam int n_corner       = 162;
  localparam int n_stall        = 500;
  localparam int n_reset_before = 20;
  localparam int n_reset_after  = 10;
  localparam int total_ops      = 1 + n_unsigned + n_mixed + n_corner + n_stall
                                + n_reset_before + n_reset_after;
  localparam int timeout_cycles = total_ops * 3 + 200;

  logic              clk = 1'b0;
  logic              reset;
  logic              ce;
  logic              in_valid;
  logic              is_signed;
  mul_pkg::operand_t a;
  mul_pkg::operand_t b;
  logic              out_valid;
  mul_pkg::product_t product;

  // expected products and the enabled-edge count at the time each was driven
  mul_pkg::product_t exp_q [$];
  int                issue_q [$];

  logic [31:0] rng_state = seed;
  int edge_count     = 0;
  int issued_count   = 0;
  int received_count = 0;
  int flushed_count  = 0;
  int check_count    = 0;
  int error_count    = 0;
  string test_name;
  int errors_at_start;
  int results_at_start;

  mul32_unit u_dut (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .in_valid  (in_valid),
    .is_signed (is_signed),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  always #50 clk = ~clk;

  // ====================
  // models and compares
  // ====================

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // low LCG bits repeat quickly, so only the upper halves of two draws are used
  function automatic mul_pkg::operand_t rand_operand();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi[31:16], lo[31:16]};
  endfunction

  // full-width product, sign-extending the operands in signed mode
  function automatic mul_pkg::product_t ref_mul(input mul_pkg::operand_t x,
                                                input mul_pkg::operand_t y,
                                                input logic signed_mode);
    logic signed [mul_pkg::prod_w-1:0] sx;
    logic signed [mul_pkg::prod_w-1:0] sy;
    logic [mul_pkg::prod_w-1:0] ux;
    logic [mul_pkg::prod_w-1:0] uy;
    sx = {{mul_pkg::op_w{x[mul_pkg::op_w-1]}}, x};
    sy = {{mul_pkg::op_w{y[mul_pkg::op_w-1]}}, y};
    ux = {{mul_pkg::op_w{1'b0}}, x};
    uy = {{mul_pkg::op_w{1'b0}}, y};
    if (signed_mode) begin
      return sx * sy;
    end else begin
      return ux * uy;
    end
  endfunction

  // zero, one, all ones, extremes, 16'hffff halves and two values with equal halves
  function automatic mul_pkg::operand_t corner_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      5:       return 32'h0000_ffff;
      6:       return 32'hffff_0000;
      7:       return 32'h1234_1234;
      default: return 32'ha5a5_a5a5;
    endcase
  endfunction

  task automatic compare_product(input mul_pkg::product_t got, input mul_pkg::product_t exp,
                                 input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_valid(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ====================
  // result checker
  // ====================

  // each posedge looks at what the previous edge produced, so outputs read here are settled
  always @(posedge clk) begin : check_results
    static logic              prev_enabled = 1'b0;
    static logic              prev_reset   = 1'b0;
    static logic              hold_armed   = 1'b0;
    static logic              held_valid   = 1'b0;
    static mul_pkg::product_t held_product = '0;
    mul_pkg::product_t exp_val;
    int                issued_at;
    if (prev_enabled && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("out_valid went high at %0t although no operation was pending", $time);
      end else begin
        exp_val   = exp_q.pop_front();
        issued_at = issue_q.pop_front();
        compare_product(product, exp_val, "product");
        compare_count(edge_count - issued_at, mul_pkg::unit_latency, "latency in enabled edges");
        received_count++;
      end
    end
    // a frozen edge must leave both outputs exactly as they were
    if (hold_armed && !prev_enabled && !prev_reset) begin
      compare_valid(out_valid, held_valid, "out_valid hold with ce low");
      compare_product(product, held_product, "product hold with ce low");
    end
    held_valid   = out_valid;
    held_product = product;
    // operations still in flight at a reset edge never come out
    if (reset) begin
      flushed_count += exp_q.size();
      exp_q.delete();
      issue_q.delete();
      hold_armed = 1'b1;
    end
    prev_reset   = reset;
    prev_enabled = ce && !reset;
    if (prev_enabled) begin
      edge_count++;
    end
  end

  // ====================
  // stimulus
  // ====================

  // drives one cycle at the falling edge and queues the expectation if the edge will accept it
  task automatic drive_cycle(input logic ce_v, input logic valid_v, input logic signed_v,
                             input mul_pkg::operand_t a_v, input mul_pkg::operand_t b_v);
    @(negedge clk);
    ce        = ce_v;
    in_valid  = valid_v;
    is_signed = signed_v;
    a         = a_v;
    b         = b_v;
    if (ce_v && valid_v) begin
      exp_q.push_back(ref_mul(a_v, b_v, signed_v));
      issue_q.push_back(edge_count);
      issued_count++;
    end
  endtask

  task automatic issue_op(input mul_pkg::operand_t a_v, input mul_pkg::operand_t b_v,
                          input logic signed_v);
    drive_cycle(1'b1, 1'b1, signed_v, a_v, b_v);
  endtask

  // idles with ce high until every queued result is back, giving up after a bounded wait
  task automatic drain_pipe();
    for (int i = 0; i < mul_pkg::unit_latency + 4; i++) begin
      if (exp_q.size() == 0) begin
        break;
      end
      drive_cycle(1'b1, 1'b0, 1'b0, '0, '0);
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d results never arrived after the pipeline was drained", exp_q.size());
    end
  endtask

  task automatic start_test(input string name);
    test_name        = name;
    errors_at_start  = error_count;
    results_at_start = received_count;
  endtask

  task automatic finish_test();
    $display("%s: %0d results, %0d errors", test_name,
             received_count - results_at_start, error_count - errors_at_start);
  endtask

  // ====================
  // tests
  // ====================

  // out_valid stays low through seven edges and rises on the eighth
  task automatic check_latency();
    start_test("latency");
    issue_op(32'h0001_2345, 32'h0006_789a, 1'b0);
    for (int i = 1; i <= mul_pkg::unit_latency; i++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, '0, '0);
      compare_valid(out_valid, i == mul_pkg::unit_latency, "out_valid during first pass");
    end
    drain_pipe();
    compare_count(received_count - results_at_start, 1, "latency results");
    finish_test();
  endtask

  task automatic unsigned_stream();
    mul_pkg::operand_t x;
    mul_pkg::operand_t y;
    start_test("unsigned stream");
    for (int i = 0; i < n_unsigned; i++) begin
      x = rand_operand();
      y = rand_operand();
      issue_op(x, y, 1'b0);
    end
    drain_pipe();
    compare_count(received_count - results_at_start, n_unsigned, "unsigned results");
    finish_test();
  endtask

  // two of every three operations are signed
  task automatic mixed_stream();
    mul_pkg::operand_t x;
    mul_pkg::operand_t y;
    start_test("mixed stream");
    for (int i = 0; i < n_mixed; i++) begin
      x = rand_operand();
      y = rand_operand();
      issue_op(x, y, (i % 3) != 0);
    end
    drain_pipe();
    compare_count(received_count - results_at_start, n_mixed, "mixed results");
    finish_test();
  endtask

  task automatic corner_operands();
    start_test("corner operands");
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 9; i++) begin
        for (int j = 0; j < 9; j++) begin
          issue_op(corner_value(i), corner_value(j), s[0]);
        end
      end
    end
    drain_pipe();
    compare_count(received_count - results_at_start, n_corner, "corner results");
    finish_test();
  endtask

  // ce is low about a quarter of the cycles and in_valid about half
  task automatic stall_stream();
    int                accepted;
    logic [31:0]       r;
    mul_pkg::operand_t x;
    mul_pkg::operand_t y;
    start_test("ce stalls");
    accepted = 0;
    while (accepted < n_stall) begin
      r = rand32();
      x = rand_operand();
      y = rand_operand();
      drive_cycle(r[31:30] != 2'b00, r[29], r[28], x, y);
      if (r[31:30] != 2'b00 && r[29]) begin
        accepted++;
      end
    end
    drain_pipe();
    compare_count(received_count - results_at_start, n_stall, "stalled results");
    finish_test();
  endtask

  // with back-to-back issue, eight accepted operations are in the unit when reset arrives
  // the oldest of them is already on the output, so reset catches the other seven
  task automatic mid_stream_reset();
    int                flushed_at_start;
    int                completed_before;
    mul_pkg::operand_t x;
    mul_pkg::operand_t y;
    start_test("mid-stream reset");
    flushed_at_start = flushed_count;
    completed_before = n_reset_before - mul_pkg::unit_latency + 1;
    for (int i = 0; i < n_reset_before; i++) begin
      x = rand_operand();
      y = rand_operand();
      issue_op(x, y, i[0]);
    end
    @(negedge clk);
    reset    = 1'b1;
    in_valid = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    compare_count(received_count - results_at_start, completed_before, "results before reset");
    compare_count(flushed_count - flushed_at_start, n_reset_before - completed_before,
                  "dropped operations");
    compare_valid(out_valid, 1'b0, "out_valid after mid-stream reset");
    for (int i = 0; i < n_reset_after; i++) begin
      x = rand_operand();
      y = rand_operand();
      issue_op(x, y, i[0]);
    end
    drain_pipe();
    compare_count(received_count - results_at_start, completed_before + n_reset_after,
                  "results overall in reset test");
    finish_test();
  endtask

  // ====================
  // sequence and watchdog
  // ====================

  initial begin
    reset     = 1'b1;
    ce        = 1'b1;
    in_valid  = 1'b0;
    is_signed = 1'b0;
    a         = '0;
    b         = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    compare_valid(out_valid, 1'b0, "out_valid after reset");
    check_latency();
    unsigned_stream();
    mixed_stream();
    corner_operands();
    stall_stream();
    mid_stream_reset();
    compare_count(received_count, issued_count - flushed_count, "results in whole run");
    $display("issued %0d, received %0d, dropped %0d, checks %0d, errors %0d",
             issued_count, received_count, flushed_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    $display("the run timed out after %0d cycles before all tests finished", timeout_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* logic/mul32_unit.sv */
// pipelined 32 by 32 multiplier, 8 ce-cycles of latency; ce stalls everything and there is no ready
`timescale 1ns/100ps

module mul32_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              ce,
  input  logic              in_valid,
  input  logic              is_signed,
  input  mul_pkg::operand_t a,
  input  mul_pkg::operand_t b,
  output logic              out_valid,
  output mul_pkg::product_t product
);

  // conditioned operands between the operand stage and the core
  mul_op_if u_op_if ();

  // unsigned core result with its flags
  logic              core_valid;
  logic              core_neg;
  mul_pkg::product_t core_p;

  // ====================
  // pipeline
  // ====================

  // magnitudes and the negate flag, one stage
  operand_prep u_operand_prep (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .in_valid  (in_valid),
    .is_signed (is_signed),
    .a         (a),
    .b         (b),
    .op        (u_op_if.prep_side)
  );

  // unsigned Karatsuba multiply, six stages
  karatsuba_mul32 u_core (
    .clk   (clk),
    .reset (reset),
    .ce    (ce),
    .op    (u_op_if.core_side),
    .valid (core_valid),
    .neg   (core_neg),
    .p     (core_p)
  );

  // sign applied to the product, one stage
  product_fix u_product_fix (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .valid     (core_valid),
    .neg       (core_neg),
    .p         (core_p),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

/* logic/product_fix.sv */
// result stage with one ce-cycle of latency; the sign decision comes in as neg and is not re-derived
`timescale 1ns/100ps

module product_fix (
  input  logic              clk,
  input  logic              reset,
  input  logic              ce,
  input  logic              valid,
  input  logic              neg,
  input  mul_pkg::product_t p,
  output logic              out_valid,
  output mul_pkg::product_t product
);

  // negated form of the unsigned product
  mul_pkg::product_t p_neg;

  // selected value ahead of the register
  mul_pkg::product_t p_sel;

  // ====================
  // sign application
  // ====================

  // 64-bit two's complement, exact for every product of two 32-bit magnitudes
  assign p_neg = -p;

  // neg is low for every unsigned operation, so the product passes unchanged
  assign p_sel = neg ? p_neg : p;

  // ====================
  // output registers
  // ====================

  // out_valid follows the core valid one enabled edge later
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (ce) begin
      out_valid <= valid;
    end
  end

  // product holds its last value while ce is low or no result is present
  always_ff @(posedge clk) begin
    if (ce) begin
      product <= p_sel;
    end
  end

endmodule

/* logic/karatsuba_mul32.sv */
// unsigned 32 by 32 Karatsuba core with six ce-cycles of latency; sign handling stays outside
`timescale 1ns/100ps

module karatsuba_mul32 (
  input  logic               clk,
  input  logic               reset,
  input  logic               ce,
  mul_op_if.core_side        op,
  output logic               valid,
  output logic               neg,
  output mul_pkg::product_t  p
);

  // halves of the incoming magnitudes
  logic [mul_pkg::half_w-1:0] a_hi;
  logic [mul_pkg::half_w-1:0] a_lo;
  logic [mul_pkg::half_w-1:0] b_hi;
  logic [mul_pkg::half_w-1:0] b_lo;

  // stage 1, the half differences keep a borrow bit as their sign
  logic [mul_pkg::half_w:0] a_diff_s1;
  logic [mul_pkg::half_w:0] b_diff_s1;
  mul_pkg::operand_t        a_s1;
  mul_pkg::operand_t        b_s1;

  // negated differences, the low half_w bits become the magnitudes
  logic [mul_pkg::half_w:0] a_diff_neg;
  logic [mul_pkg::half_w:0] b_diff_neg;

  // stage 2
  logic [mul_pkg::half_w-1:0] a_dmag_s2;
  logic [mul_pkg::half_w-1:0] b_dmag_s2;
  logic                       dsgn_s2;
  mul_pkg::operand_t          a_s2;
  mul_pkg::operand_t          b_s2;

  // stage 3, the three products
  mul_pkg::half_prod_t z2_s3;
  mul_pkg::half_prod_t z0_s3;
  mul_pkg::half_prod_t pm_s3;
  logic                dsgn_s3;

  // stage 4, one extra bit covers the carry of z0 plus z2
  logic [mul_pkg::op_w:0] mid_s4;
  logic [mul_pkg::op_w:0] zs_s4;

  // stage 5
  logic [mul_pkg::op_w:0] z1_s5;

  // z0 and z2 after alignment with z1
  mul_pkg::half_prod_t z2_s5;
  mul_pkg::half_prod_t z0_s5;

  // stage 6
  mul_pkg::product_t p_s6;

  assign a_hi = op.a_mag[mul_pkg::op_w-1:mul_pkg::half_w];
  assign a_lo = op.a_mag[mul_pkg::half_w-1:0];
  assign b_hi = op.b_mag[mul_pkg::op_w-1:mul_pkg::half_w];
  assign b_lo = op.b_mag[mul_pkg::half_w-1:0];

  // ====================
  // stages 1 and 2
  // ====================

  // the differences run in opposite directions for a and b
  // so their product plus z0 plus z2 gives the middle term directly
  always_ff @(posedge clk) begin
    if (ce) begin
      a_diff_s1 <= {1'b0, a_lo} - {1'b0, a_hi};
      b_diff_s1 <= {1'b0, b_hi} - {1'b0, b_lo};
      a_s1      <= op.a_mag;
      b_s1      <= op.b_mag;
    end
  end

  assign a_diff_neg = -a_diff_s1;
  assign b_diff_neg = -b_diff_s1;

  // a magnitude always fits in half_w bits, even for a difference of -65535
  always_ff @(posedge clk) begin
    if (ce) begin
      a_dmag_s2 <= a_diff_s1[mul_pkg::half_w] ? a_diff_neg[mul_pkg::half_w-1:0]
                                              : a_diff_s1[mul_pkg::half_w-1:0];
      b_dmag_s2 <= b_diff_s1[mul_pkg::half_w] ? b_diff_neg[mul_pkg::half_w-1:0]
                                              : b_diff_s1[mul_pkg::half_w-1:0];
      dsgn_s2   <= a_diff_s1[mul_pkg::half_w] ^ b_diff_s1[mul_pkg::half_w];
      a_s2      <= a_s1;
      b_s2      <= b_s1;
    end
  end

  // ====================
  // stage 3
  // ====================

  // three 16 by 16 multiplies in place of four
  // the 32-bit target widens the operands so nothing is lost
  always_ff @(posedge clk) begin
    if (ce) begin
      z2_s3   <= a_s2[mul_pkg::op_w-1:mul_pkg::half_w] * b_s2[mul_pkg::op_w-1:mul_pkg::half_w];
      z0_s3   <= a_s2[mul_pkg::half_w-1:0] * b_s2[mul_pkg::half_w-1:0];
      pm_s3   <= a_dmag_s2 * b_dmag_s2;
      dsgn_s3 <= dsgn_s2;
    end
  end

  // ====================
  // stages 4 and 5
  // ====================

  // the negation runs in 33 bits so a zero middle product with its sign set stays zero
  always_ff @(posedge clk) begin
    if (ce) begin
      mid_s4 <= dsgn_s3 ? -{1'b0, pm_s3} : {1'b0, pm_s3};
      zs_s4  <= {1'b0, z0_s3} + {1'b0, z2_s3};
    end
  end

  // z1 is the sum of the cross products, below 2**33, so the wrap of the signed add is harmless
  always_ff @(posedge clk) begin
    if (ce) begin
      z1_s5 <= zs_s4 + mid_s4;
    end
  end

  // z0 and z2 wait two stages while the middle term is formed
  delay_line #(
    .payload_t (mul_pkg::half_prod_t),
    .depth     (2)
  ) u_z2_line (
    .clk   (clk),
    .reset (reset),
    .ce    (ce),
    .d     (z2_s3),
    .q     (z2_s5)
  );

  delay_line #(
    .payload_t (mul_pkg::half_prod_t),
    .depth     (2)
  ) u_z0_line (
    .clk   (clk),
    .reset (reset),
    .ce    (ce),
    .d     (z0_s3),
    .q     (z0_s5)
  );

  // ====================
  // stage 6
  // ====================

  // z2 and z0 sit side by side, the middle term lands half_w bits up
  always_ff @(posedge clk) begin
    if (ce) begin
      p_s6 <= {z2_s5, z0_s5}
            + {{(mul_pkg::prod_w - mul_pkg::op_w - mul_pkg::half_w - 1){1'b0}},
               z1_s5, {mul_pkg::half_w{1'b0}}};
    end
  end

  assign p = p_s6;

  // ====================
  // flag tracking
  // ====================

  // valid and neg follow the data through all six stages
  delay_line #(
    .payload_t (logic),
    .depth     (mul_pkg::core_latency)
  ) u_valid_line (
    .clk   (clk),
    .reset (reset),
    .ce    (ce),
    .d     (op.valid),
    .q     (valid)
  );

  delay_line #(
    .payload_t (logic),
    .depth     (mul_pkg::core_latency)
  ) u_neg_line (
    .clk   (clk),
    .reset (reset),
    .ce    (ce),
    .d     (op.neg),
    .q     (neg)
  );

endmodule

/* logic/operand_prep.sv */
// operand stage with one ce-cycle of latency; the most negative value passes as its unsigned pattern
`timescale 1ns/100ps

module operand_prep (
  input  logic              clk,
  input  logic              reset,
  input  logic              ce,
  input  logic              in_valid,
  input  logic              is_signed,
  input  mul_pkg::operand_t a,
  input  mul_pkg::operand_t b,
  mul_op_if.prep_side       op
);

  // an operand counts as negative only in signed mode
  logic a_neg;
  logic b_neg;

  // two's-complement magnitudes before the register
  mul_pkg::operand_t a_abs;
  mul_pkg::operand_t b_abs;

  // registered stage outputs
  logic              valid_q;
  logic              neg_q;
  mul_pkg::operand_t a_mag_q;
  mul_pkg::operand_t b_mag_q;

  // ====================
  // sign handling
  // ====================

  assign a_neg = is_signed & a[mul_pkg::op_w-1];
  assign b_neg = is_signed & b[mul_pkg::op_w-1];

  // negating 32'h8000_0000 gives the same pattern, which is the right unsigned magnitude
  assign a_abs = a_neg ? -a : a;
  assign b_abs = b_neg ? -b : b;

  // ====================
  // registers
  // ====================

  // the product is negative when exactly one operand is negative
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      neg_q   <= 1'b0;
    end else if (ce) begin
      valid_q <= in_valid;
      neg_q   <= a_neg ^ b_neg;
    end
  end

  // magnitudes carry no meaning while valid_q is low
  always_ff @(posedge clk) begin
    if (ce) begin
      a_mag_q <= a_abs;
      b_mag_q <= b_abs;
    end
  end

  // hand the registered values to the core
  assign op.valid = valid_q;
  assign op.neg   = neg_q;
  assign op.a_mag = a_mag_q;
  assign op.b_mag = b_mag_q;

endmodule

/* logic/delay_line.sv */
// shift register of depth stages (depth of at least 1); all stages move on ce and clear on reset
`timescale 1ns/100ps

module delay_line #(
  parameter type payload_t = logic,
  parameter int depth = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     ce,
  input  payload_t d,
  output payload_t q
);

  // stage 0 takes d, the last stage drives q
  payload_t stage [depth];

  // ====================
  // shift chain
  // ====================

  // every stage holds while ce is low, so the line freezes with the rest of the pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        stage[i] <= '0;
      end
    end else if (ce) begin
      stage[0] <= d;
      // each later stage takes the value of the stage before it
      for (int i = 1; i < depth; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // output is the oldest entry in the chain
  assign q = stage[depth-1];

endmodule

/* logic/mul_op_if.sv */
// conditioned operands from the operand stage to the core; magnitudes are unsigned, neg holds the sign
`timescale 1ns/100ps

interface mul_op_if;

  // the operand at this stage is meaningful only while valid is high
  logic valid;

  // unsigned magnitudes of the two operands
  mul_pkg::operand_t a_mag;
  mul_pkg::operand_t b_mag;

  // high when the final product must be negated
  // it rides alongside the data through the core
  logic neg;

  // the operand stage drives every signal
  modport prep_side (
    output valid,
    output a_mag,
    output b_mag,
    output neg
  );

  // the core only reads
  modport core_side (
    input valid,
    input a_mag,
    input b_mag,
    input neg
  );

endinterface

/* logic/mul_pkg.sv */
// shared widths, latencies and types for the multiplier; widths are fixed at 32 by 32
package mul_pkg;

  // ====================
  // widths
  // ====================

  // width of each operand at the unit boundary
  localparam int op_w = 32;

  // the core splits every operand into two halves of this width
  localparam int half_w = 16;

  // full product width, twice the operand width
  localparam int prod_w = 64;

  // ====================
  // latencies
  // ====================

  // ce-enabled edges from the core inputs to its unsigned product
  localparam int core_latency = 6;

  // operand stage, core and result stage together
  // a sample accepted at one enabled edge shows up this many enabled edges later
  localparam int unit_latency = 8;

  // ====================
  // types
  // ====================

  // operands are unsigned magnitudes once they leave the operand stage
  typedef logic [op_w-1:0] operand_t;

  // unsigned product as it leaves the core, later the signed result
  typedef logic [prod_w-1:0] product_t;

  // product of two halves, the payload of the z0 and z2 alignment lines
  typedef logic [2*half_w-1:0] half_prod_t;

endpackage
